//--- common/tank_pkg.sv
// tank game shared types
package tank_pkg;

	localparam int GRID_BITS = 5;	// 32 x 32 cells

	localparam logic [GRID_BITS-1:0] START_X = 16;
	localparam logic [GRID_BITS-1:0] START_Y = 16;

	typedef struct packed {
		logic [GRID_BITS-1:0] x;
		logic [GRID_BITS-1:0] y;
	} pos_t;

	// up decreases y, right increases x
	typedef enum logic [1:0] {
		DIR_UP,
		DIR_LEFT,
		DIR_DOWN,
		DIR_RIGHT
	} dir_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} game_state_t;

	typedef struct packed {
		logic up;
		logic left;
		logic down;
		logic right;
		logic fire;
		logic start;
	} btn_t;

	typedef struct packed {
		logic active;
		pos_t pos;
		dir_t dir;
	} bullet_t;

	// set when one step in d would leave the grid
	function automatic logic at_edge(pos_t p, dir_t d);
		case (d)
			DIR_UP:   return p.y == '0;
			DIR_LEFT: return p.x == '0;
			DIR_DOWN: return p.y == '1;
			default:  return p.x == '1;
		endcase
	endfunction

	// one cell in d, no border check
	function automatic pos_t step_pos(pos_t p, dir_t d);
		pos_t n;
		n = p;
		case (d)
			DIR_UP:   n.y = p.y - 1'b1;
			DIR_LEFT: n.x = p.x - 1'b1;
			DIR_DOWN: n.y = p.y + 1'b1;
			default:  n.x = p.x + 1'b1;
		endcase
		return n;
	endfunction

endpackage

//--- flist.f
common/tank_pkg.sv
hw/game_mode_fsm.sv
hw/move_tick_timer.sv
tank/tank_motion.sv
tank/bullet_flight.sv
hw/tank_game_top.sv
test/tank_game_assert.sv
test/tb_tank_game.sv

//--- hw/game_mode_fsm.sv
// game mode state machine
`timescale 1ns/1ns

module game_mode_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  round_done,
	output tank_pkg::game_state_t game_state,
	output logic                  round_start
);

	logic start_q;
	logic start_rise;

	assign start_rise = start & ~start_q;	// press, not hold

	always_ff @(posedge clk) begin
		if (rst) begin
			start_q     <= 1'b0;
			game_state  <= tank_pkg::ST_IDLE;
			round_start <= 1'b0;
		end else begin
			start_q     <= start;
			round_start <= 1'b0;	// single cycle pulse
			case (game_state)
				tank_pkg::ST_IDLE: begin
					if (start_rise) begin
						game_state  <= tank_pkg::ST_PLAY;
						round_start <= 1'b1;	// lines up with first play cycle
					end
				end
				tank_pkg::ST_PLAY: begin
					if (round_done)
						game_state <= tank_pkg::ST_OVER;
				end
				tank_pkg::ST_OVER: begin
					// back to idle, the next press starts a fresh round
					if (start_rise)
						game_state <= tank_pkg::ST_IDLE;
				end
				default: game_state <= tank_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/move_tick_timer.sv
// movement tick and round timer
`timescale 1ns/1ns

module move_tick_timer #(
	parameter int TICK_DIV    = 4,
	parameter int ROUND_TICKS = 48
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  round_start,
	input  tank_pkg::game_state_t game_state,
	output logic                  move_tick,
	output logic                  round_done
);

	localparam int DIV_W = $clog2(TICK_DIV + 1);
	localparam int RND_W = $clog2(ROUND_TICKS + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [RND_W-1:0] ticks_left;
	logic             playing;

	// divider held at zero through the round_start cycle
	assign playing    = (game_state == tank_pkg::ST_PLAY) && !round_start;
	assign move_tick  = playing && (div_cnt == DIV_W'(TICK_DIV - 1));
	assign round_done = move_tick && (ticks_left == '0);

	always_ff @(posedge clk) begin
		if (rst || !playing)
			div_cnt <= '0;
		else if (move_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// counts down, zero marks the last tick of the round
	always_ff @(posedge clk) begin
		if (rst)
			ticks_left <= '0;
		else if (round_start)
			ticks_left <= RND_W'(ROUND_TICKS - 1);
		else if (move_tick && ticks_left != '0)
			ticks_left <= ticks_left - 1'b1;
	end

endmodule

//--- hw/tank_game_top.sv
// tank game top level
`timescale 1ns/1ns

module tank_game_top #(
	parameter int TICK_DIV    = 4,
	parameter int ROUND_TICKS = 48
) (
	input  logic                  clk,
	input  logic                  rst,
	input  tank_pkg::btn_t        btn,
	output tank_pkg::game_state_t game_state,
	output tank_pkg::pos_t        tank_pos,
	output tank_pkg::dir_t        tank_dir,
	output tank_pkg::bullet_t     bullet
);

	logic round_start;	// first cycle of play
	logic round_done;	// last tick of the round
	logic move_tick;

	game_mode_fsm u_game_mode_fsm (
		.clk         (clk),
		.rst         (rst),
		.start       (btn.start),
		.round_done  (round_done),
		.game_state  (game_state),
		.round_start (round_start)
	);

	move_tick_timer #(
		.TICK_DIV    (TICK_DIV),
		.ROUND_TICKS (ROUND_TICKS)
	) u_move_tick_timer (
		.clk         (clk),
		.rst         (rst),
		.round_start (round_start),
		.game_state  (game_state),
		.move_tick   (move_tick),
		.round_done  (round_done)
	);

	tank_motion u_tank_motion (
		.clk         (clk),
		.rst         (rst),
		.round_start (round_start),
		.move_tick   (move_tick),
		.btn         (btn),
		.tank_pos    (tank_pos),
		.tank_dir    (tank_dir)
	);

	bullet_flight u_bullet_flight (
		.clk         (clk),
		.rst         (rst),
		.round_start (round_start),
		.move_tick   (move_tick),
		.fire        (btn.fire),
		.game_state  (game_state),
		.tank_pos    (tank_pos),
		.tank_dir    (tank_dir),
		.bullet      (bullet)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the tank game testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_tank_game \
	-f flist.f \
	-o sim_tank_game

./obj_dir/sim_tank_game > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
	exit 1
fi

//--- tank/bullet_flight.sv
// player bullet
`timescale 1ns/1ns

module bullet_flight (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  round_start,
	input  logic                  move_tick,
	input  logic                  fire,
	input  tank_pkg::game_state_t game_state,
	input  tank_pkg::pos_t        tank_pos,
	input  tank_pkg::dir_t        tank_dir,
	output tank_pkg::bullet_t     bullet
);

	logic           fire_q;
	logic           launch;
	logic           blocked;
	logic           active_q;
	tank_pkg::pos_t pos_q;
	tank_pkg::dir_t dir_q;

	// one bullet on the field at a time
	assign launch = fire && !fire_q && !active_q
		&& (game_state == tank_pkg::ST_PLAY);
	assign blocked = tank_pkg::at_edge(pos_q, dir_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			fire_q   <= 1'b0;
			active_q <= 1'b0;
		end else begin
			fire_q <= fire;
			if (round_start)
				active_q <= 1'b0;
			else if (launch)
				active_q <= 1'b1;
			else if (move_tick && active_q && blocked)
				active_q <= 1'b0;	// retires at the border
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			pos_q <= tank_pos;	// leaves from the tank's own cell
			dir_q <= tank_dir;
		end else if (move_tick && active_q && !blocked) begin
			pos_q <= tank_pkg::step_pos(pos_q, dir_q);
		end
	end

	assign bullet = '{active: active_q, pos: pos_q, dir: dir_q};

endmodule

//--- tank/tank_motion.sv
// player tank motion
`timescale 1ns/1ns

module tank_motion (
	input  logic           clk,
	input  logic           rst,
	input  logic           round_start,
	input  logic           move_tick,
	input  tank_pkg::btn_t btn,
	output tank_pkg::pos_t tank_pos,
	output tank_pkg::dir_t tank_dir
);

	tank_pkg::dir_t req_dir;
	logic           req_valid;

	// up, left, down, right in falling priority
	always_comb begin
		req_valid = 1'b1;
		if (btn.up)
			req_dir = tank_pkg::DIR_UP;
		else if (btn.left)
			req_dir = tank_pkg::DIR_LEFT;
		else if (btn.down)
			req_dir = tank_pkg::DIR_DOWN;
		else if (btn.right)
			req_dir = tank_pkg::DIR_RIGHT;
		else begin
			req_valid = 1'b0;
			req_dir   = tank_dir;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || round_start) begin
			tank_pos.x <= tank_pkg::START_X;
			tank_pos.y <= tank_pkg::START_Y;
			tank_dir   <= tank_pkg::DIR_UP;
		end else if (move_tick && req_valid) begin
			tank_dir <= req_dir;	// turns even when blocked
			if (!tank_pkg::at_edge(tank_pos, req_dir))
				tank_pos <= tank_pkg::step_pos(tank_pos, req_dir);
		end
	end

endmodule

//--- test/tank_game_assert.sv
// bullet and state rule checks
`timescale 1ns/1ns

module tank_game_assert (
	input logic                  clk,
	input logic                  rst,
	input tank_pkg::game_state_t game_state,
	input logic                  launch,
	input tank_pkg::pos_t        tank_pos,
	input tank_pkg::bullet_t     bullet
);

	// no bullet in flight outside a round
	assert property (@(posedge clk) disable iff (rst)
		game_state != tank_pkg::ST_PLAY |-> !bullet.active)
		else $error("bullet active outside play");

	assert property (@(posedge clk) disable iff (rst)
		launch |=> bullet.active && bullet.pos == $past(tank_pos))
		else $error("bullet did not start at the tank cell");

	// idle only leads to play
	assert property (@(posedge clk) disable iff (rst)
		game_state == tank_pkg::ST_IDLE |=> game_state != tank_pkg::ST_OVER)
		else $error("state jumped from idle to over");

endmodule

bind bullet_flight tank_game_assert u_assert (
	.clk        (clk),
	.rst        (rst),
	.game_state (game_state),
	.launch     (launch),
	.tank_pos   (tank_pos),
	.bullet     (bullet)
);

//--- test/tb_tank_game.sv
// tank game testbench
`timescale 1ns/1ns

module tb_tank_game;

	localparam int TICK_DIV    = 4;
	localparam int ROUND_TICKS = 48;
	localparam int MAX_CYCLES  = 4000;	// well beyond reset, one round and the restart
	localparam int STEP_LIMIT  = 2 * TICK_DIV + 2;

	logic                  clk = 1'b0;
	logic                  rst;
	tank_pkg::btn_t        btn;
	tank_pkg::game_state_t game_state;
	tank_pkg::pos_t        tank_pos;
	tank_pkg::dir_t        tank_dir;
	tank_pkg::bullet_t     bullet;

	int errors = 0;
	int tests_run = 0;
	int cycles = 0;

	tank_game_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.btn        (btn),
		.game_state (game_state),
		.tank_pos   (tank_pos),
		.tank_dir   (tank_dir),
		.bullet     (bullet)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic fail_value(string sig, logic [31:0] got, logic [31:0] exp);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", sig, got, exp);
		errors++;
	endtask

	task automatic fail_text(string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic finish_test(string name, int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
	endtask

	task automatic press_start();
		@(posedge clk) btn.start <= 1'b1;
		@(posedge clk) btn.start <= 1'b0;
		@(negedge clk);
	endtask

	// waits for the tank to change cell and returns at the following negedge
	task automatic wait_tank_step(output logic moved);
		tank_pkg::pos_t old;
		int n;
		old = tank_pos;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (tank_pos == old && n < STEP_LIMIT);
		moved = (tank_pos != old);
		assert (moved)
			else fail_text("tank did not move while a direction was held");
	endtask

	task automatic wait_bullet_step(output logic moved);
		tank_pkg::bullet_t old;
		int n;
		old = bullet;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (bullet == old && n < STEP_LIMIT);
		moved = (bullet != old);
		assert (moved)
			else fail_text("bullet did not advance on a tick");
	endtask

	task automatic test_reset_start();
		int e0;
		e0 = errors;
		assert (game_state == tank_pkg::ST_IDLE)
			else fail_value("game_state", game_state, tank_pkg::ST_IDLE);
		assert (tank_pos.x == 5'd16 && tank_pos.y == 5'd16)
			else fail_value("tank_pos", tank_pos, {5'd16, 5'd16});
		assert (tank_dir == tank_pkg::DIR_UP)
			else fail_value("tank_dir", tank_dir, tank_pkg::DIR_UP);
		assert (!bullet.active) else fail_value("bullet.active", bullet.active, 0);
		press_start();
		assert (game_state == tank_pkg::ST_PLAY)
			else fail_value("game_state", game_state, tank_pkg::ST_PLAY);
		finish_test("reset and start", e0);
	endtask

	task automatic test_move_right();
		int e0;
		int hold;
		logic moved;
		tank_pkg::pos_t prev;
		e0 = errors;
		hold = 1 + int'($urandom % 3);	// keeps the round long enough
		@(posedge clk) btn.right <= 1'b1;
		for (int i = 0; i < hold; i++) begin
			prev = tank_pos;
			wait_tank_step(moved);
			assert (tank_pos.x == prev.x + 5'd1)
				else fail_value("tank_pos.x", tank_pos.x, prev.x + 5'd1);
			assert (tank_pos.y == prev.y) else fail_value("tank_pos.y", tank_pos.y, prev.y);
		end
		@(posedge clk) btn.right <= 1'b0;
		prev = tank_pos;
		repeat (2 * TICK_DIV) @(negedge clk);
		assert (tank_pos == prev) else fail_value("tank_pos", tank_pos, prev);
		finish_test("move right", e0);
	endtask

	task automatic test_left_edge();
		int e0;
		int guard;
		logic moved;
		tank_pkg::pos_t prev;
		e0 = errors;
		guard = 0;
		@(posedge clk) btn.left <= 1'b1;
		while (tank_pos.x != 5'd0 && guard < 40) begin
			prev = tank_pos;
			wait_tank_step(moved);
			assert (tank_pos.x == prev.x - 5'd1)
				else fail_value("tank_pos.x", tank_pos.x, prev.x - 5'd1);
			guard++;
		end
		repeat (2 * TICK_DIV) @(negedge clk);	// ticks against the edge
		assert (tank_pos.x == 5'd0) else fail_value("tank_pos.x", tank_pos.x, 0);
		assert (tank_dir == tank_pkg::DIR_LEFT)
			else fail_value("tank_dir", tank_dir, tank_pkg::DIR_LEFT);
		@(posedge clk) btn.left <= 1'b0;
		finish_test("left edge", e0);
	endtask

	task automatic test_bullet();
		int e0;
		logic moved;
		logic [4:0] exp_y;
		tank_pkg::pos_t prev;
		e0 = errors;
		@(posedge clk) btn.up <= 1'b1;
		while (tank_pos.y > 5'd8) begin	// short flight for the round budget
			prev = tank_pos;
			wait_tank_step(moved);
			assert (tank_pos.y == prev.y - 5'd1)
				else fail_value("tank_pos.y", tank_pos.y, prev.y - 5'd1);
		end
		@(posedge clk) btn.up <= 1'b0;
		@(negedge clk);
		assert (tank_dir == tank_pkg::DIR_UP)
			else fail_value("tank_dir", tank_dir, tank_pkg::DIR_UP);
		@(posedge clk) btn.fire <= 1'b1;
		@(posedge clk) btn.fire <= 1'b0;
		@(negedge clk);
		exp_y = 5'd8;	// tank sits at x 0, y 8 after the climb
		assert (bullet.active) else fail_value("bullet.active", bullet.active, 1);
		assert (bullet.pos.x == 5'd0 && bullet.pos.y == exp_y)
			else fail_value("bullet.pos", bullet.pos, {5'd0, exp_y});
		assert (bullet.dir == tank_pkg::DIR_UP)
			else fail_value("bullet.dir", bullet.dir, tank_pkg::DIR_UP);
		while (exp_y != 5'd0 && bullet.active) begin
			wait_bullet_step(moved);
			exp_y = exp_y - 5'd1;
			assert (bullet.pos.y == exp_y) else fail_value("bullet.pos.y", bullet.pos.y, exp_y);
			if (exp_y == 5'd6) begin
				// a second press in flight must not relaunch
				@(posedge clk) btn.fire <= 1'b1;
				@(posedge clk) btn.fire <= 1'b0;
				@(negedge clk);
				assert (bullet.active) else fail_value("bullet.active", bullet.active, 1);
				assert (bullet.pos.y == exp_y)
					else fail_value("bullet.pos.y", bullet.pos.y, exp_y);
			end
		end
		wait_bullet_step(moved);
		assert (!bullet.active) else fail_value("bullet.active", bullet.active, 0);
		finish_test("bullet flight", e0);
	endtask

	task automatic test_round_over();
		int e0;
		int n;
		tank_pkg::pos_t prev;
		e0 = errors;
		n = 0;
		@(posedge clk) btn.left <= 1'b1;	// blocked at x 0, only turns
		while (game_state != tank_pkg::ST_OVER && n < (ROUND_TICKS + 2) * TICK_DIV) begin
			@(negedge clk);
			n++;
		end
		assert (game_state == tank_pkg::ST_OVER)
			else fail_text("round never ended after its ticks");
		assert (tank_dir == tank_pkg::DIR_LEFT)
			else fail_value("tank_dir", tank_dir, tank_pkg::DIR_LEFT);
		@(posedge clk) begin
			btn.left  <= 1'b0;
			btn.right <= 1'b1;
		end
		prev = tank_pos;
		repeat (3 * TICK_DIV) @(negedge clk);
		assert (tank_pos == prev) else fail_value("tank_pos", tank_pos, prev);
		@(posedge clk) btn.right <= 1'b0;
		press_start();
		assert (game_state == tank_pkg::ST_IDLE)
			else fail_value("game_state", game_state, tank_pkg::ST_IDLE);
		press_start();
		@(negedge clk);	// round_start cycle has passed
		assert (game_state == tank_pkg::ST_PLAY)
			else fail_value("game_state", game_state, tank_pkg::ST_PLAY);
		assert (tank_pos.x == 5'd16 && tank_pos.y == 5'd16)
			else fail_value("tank_pos", tank_pos, {5'd16, 5'd16});
		assert (tank_dir == tank_pkg::DIR_UP)
			else fail_value("tank_dir", tank_dir, tank_pkg::DIR_UP);
		finish_test("round over and restart", e0);
	endtask

	initial begin
		void'($urandom(39));
		rst <= 1'b1;
		btn <= '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		test_reset_start();
		test_move_right();
		test_left_edge();
		test_bullet();
		test_round_over();
		$display("tests run %0d, checks failed %0d", tests_run, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
